// File: sources.f
common/core_pkg.sv
hdl/fetch_unit.sv
idu/idu.sv
hdl/exu.sv
hdl/regfile.sv
hdl/cpu_core.sv
dv/cpu_core_tb.sv

// File: dv/cpu_core_tb.sv
`default_nettype none

module cpu_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS = 21;
  localparam int CYCLE_LIMIT = 4 * NUM_ROWS + 50;
  localparam logic [31:0] LFSR_SEED = 32'h15a9;
  localparam logic [31:0] NOP_INST = 32'h0000_0013;
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
  // add x11, x1, x2 is outside the supported subset
  localparam logic [31:0] ADD_WORD = {7'b0, 5'd2, 5'd1, 3'b000, 5'd11, 7'b0110011};

  // next-pc kinds in the table
  localparam logic [1:0] NEXT_SEQ = 2'd0;
  localparam logic [1:0] NEXT_JUMP = 2'd1;
  localparam logic [1:0] NEXT_HOLD = 2'd2;

  logic                        clk;
  logic                        rst_n;
  logic [core_pkg::INST_W-1:0] inst;
  logic [core_pkg::XLEN-1:0]   pc;
  logic                        retire;
  logic [4:0]                  retire_rd;
  logic [core_pkg::XLEN-1:0]   retire_data;
  logic                        illegal;
  logic                        halted;

  // stimulus table with one row per cycle
  logic [31:0] row_inst [NUM_ROWS];
  // immediate the row was encoded with, sign extended
  logic [63:0] row_imm [NUM_ROWS];
  logic        row_illegal [NUM_ROWS];
  logic        row_halted [NUM_ROWS];
  logic [1:0]  row_next [NUM_ROWS];
  int          row_count;

  // reference model state
  logic [core_pkg::XLEN-1:0] model_regs [32];
  logic [core_pkg::XLEN-1:0] model_pc;
  logic                      model_halted;

  int          error_count;
  int          timeout_count;
  int          cycle_count;
  logic [31:0] lfsr_state;

  cpu_core cpu_core_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .inst        (inst),
    .pc          (pc),
    .retire      (retire),
    .retire_rd   (retire_rd),
    .retire_data (retire_data),
    .illegal     (illegal),
    .halted      (halted)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_upper(input logic [6:0] opc, input logic [4:0] rd,
                                            input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic add_row(input logic [31:0] word, input logic [63:0] imm, input logic ill,
                         input logic hlt, input logic [1:0] nxt);
    row_inst[row_count] = word;
    row_imm[row_count] = imm;
    row_illegal[row_count] = ill;
    row_halted[row_count] = hlt;
    row_next[row_count] = nxt;
    row_count++;
  endtask

  task automatic build_table();
    logic [31:0] rnd_rd;
    logic [31:0] rnd_imm;
    add_row(enc_addi(5'd1, 5'd0, 12'd5), 64'd5, 1'b0, 1'b0, NEXT_SEQ);
    // chain through just-written registers with negative immediates
    add_row(enc_addi(5'd2, 5'd1, -12'sd3), -64'sd3, 1'b0, 1'b0, NEXT_SEQ);
    add_row(enc_addi(5'd3, 5'd2, -12'sd100), -64'sd100, 1'b0, 1'b0, NEXT_SEQ);
    take_bits(5, rnd_rd);
    take_bits(12, rnd_imm);
    add_row(enc_addi(rnd_rd[4:0], 5'd1, rnd_imm[11:0]), {{52{rnd_imm[11]}}, rnd_imm[11:0]},
            1'b0, 1'b0, NEXT_SEQ);
    take_bits(5, rnd_rd);
    take_bits(12, rnd_imm);
    add_row(enc_addi(rnd_rd[4:0], 5'd3, rnd_imm[11:0]), {{52{rnd_imm[11]}}, rnd_imm[11:0]},
            1'b0, 1'b0, NEXT_SEQ);
    add_row(enc_upper(7'b0110111, 5'd4, 20'h12345), 64'h0000_0000_1234_5000,
            1'b0, 1'b0, NEXT_SEQ);
    add_row(enc_upper(7'b0110111, 5'd5, 20'h80001), 64'hffff_ffff_8000_1000,
            1'b0, 1'b0, NEXT_SEQ);
    add_row(enc_upper(7'b0010111, 5'd6, 20'h00010), 64'h0000_0000_0001_0000,
            1'b0, 1'b0, NEXT_SEQ);
    add_row(enc_upper(7'b0010111, 5'd7, 20'hfffff), 64'hffff_ffff_ffff_f000,
            1'b0, 1'b0, NEXT_SEQ);
    add_row(enc_jal(5'd8, 21'd16), 64'd16, 1'b0, 1'b0, NEXT_JUMP);
    // x0 write retires but leaves x0 at zero
    add_row(enc_addi(5'd0, 5'd1, 12'd77), 64'd77, 1'b0, 1'b0, NEXT_SEQ);
    add_row(enc_addi(5'd9, 5'd0, 12'd33), 64'd33, 1'b0, 1'b0, NEXT_SEQ);
    add_row(enc_jal(5'd10, 21'h1f_fff8), -64'sd8, 1'b0, 1'b0, NEXT_JUMP);
    add_row(ADD_WORD, '0, 1'b1, 1'b0, NEXT_SEQ);
    add_row(enc_addi(5'd12, 5'd9, 12'd1), 64'd1, 1'b0, 1'b0, NEXT_SEQ);
    add_row(enc_jal(5'd0, 21'd2048), 64'd2048, 1'b0, 1'b0, NEXT_JUMP);
    add_row(EBREAK_WORD, '0, 1'b0, 1'b0, NEXT_HOLD);
    // halted from here on
    add_row(enc_addi(5'd13, 5'd1, 12'd1), 64'd1, 1'b0, 1'b1, NEXT_HOLD);
    add_row(enc_jal(5'd1, 21'd8), 64'd8, 1'b0, 1'b1, NEXT_HOLD);
    add_row(ADD_WORD, '0, 1'b0, 1'b1, NEXT_HOLD);
    add_row(enc_addi(5'd14, 5'd0, 12'd9), 64'd9, 1'b0, 1'b1, NEXT_HOLD);
  endtask

  // expected retire values from the instruction semantics
  task automatic predict(input logic [31:0] word, input logic [63:0] imm,
                         output logic exp_retire, output logic [4:0] exp_rd,
                         output logic [63:0] exp_data, output logic [63:0] exp_target,
                         output logic is_ebreak);
    exp_retire = 1'b0;
    exp_rd = word[11:7];
    exp_data = '0;
    exp_target = model_pc;
    is_ebreak = 1'b0;
    if (!model_halted) begin
      if (word == EBREAK_WORD) begin
        is_ebreak = 1'b1;
      end else begin
        case (word[6:0])
          7'b0010011: begin
            if (word[14:12] == 3'b000) begin
              exp_retire = 1'b1;
              exp_data = model_regs[word[19:15]] + imm;
            end
          end
          7'b0110111: begin
            exp_retire = 1'b1;
            exp_data = imm;
          end
          7'b0010111: begin
            exp_retire = 1'b1;
            exp_data = model_pc + imm;
          end
          7'b1101111: begin
            exp_retire = 1'b1;
            exp_data = model_pc + 64'd4;
            exp_target = model_pc + imm;
          end
          default: begin
          end
        endcase
      end
    end
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("CHECK FAILED at %0.1f ns: %s expected %h, got %h", $realtime, name, exp, act);
    error_count++;
  endtask

  task automatic print_summary();
    $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
  endtask

  initial begin
    logic        exp_retire;
    logic [4:0]  exp_rd;
    logic [63:0] exp_data;
    logic [63:0] exp_target;
    logic        is_ebreak;
    clk = 1'b0;
    rst_n = 1'b0;
    inst = NOP_INST;
    error_count = 0;
    timeout_count = 0;
    row_count = 0;
    lfsr_state = LFSR_SEED;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    model_pc = core_pkg::RESET_PC;
    model_halted = 1'b0;
    build_table();

    repeat (8) @(posedge clk);
    #0.5;
    rst_n = 1'b1;

    for (int i = 0; i < NUM_ROWS; i++) begin
      if (pc !== model_pc) report_mismatch("pc", model_pc, pc);
      if (halted !== row_halted[i]) report_mismatch("halted", row_halted[i], halted);
      inst = row_inst[i];
      predict(row_inst[i], row_imm[i], exp_retire, exp_rd, exp_data, exp_target, is_ebreak);

      // combinational results settle well before the falling edge
      @(negedge clk);
      if (retire !== exp_retire) report_mismatch("retire", exp_retire, retire);
      if (illegal !== row_illegal[i]) report_mismatch("illegal", row_illegal[i], illegal);
      if (exp_retire) begin
        if (retire_rd !== exp_rd) report_mismatch("retire_rd", exp_rd, retire_rd);
        if (retire_data !== exp_data) report_mismatch("retire_data", exp_data, retire_data);
      end

      if (exp_retire && (exp_rd != 5'd0)) begin
        model_regs[exp_rd] = exp_data;
      end
      if (is_ebreak) begin
        model_halted = 1'b1;
      end
      case (row_next[i])
        NEXT_JUMP: model_pc = exp_target;
        NEXT_HOLD: model_pc = model_pc;
        default: model_pc = model_pc + 64'd4;
      endcase

      @(posedge clk);
      #0.5;
    end

    print_summary();
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    timeout_count++;
    $display("timeout after %0d cycles, the stimulus table did not complete", cycle_count);
    print_summary();
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/cpu_core.sv
`default_nettype none

module cpu_core (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire  [core_pkg::INST_W-1:0]     inst,
  output logic [core_pkg::XLEN-1:0]       pc,
  output logic                            retire,
  output logic [core_pkg::REG_ADDR_W-1:0] retire_rd,
  output logic [core_pkg::XLEN-1:0]       retire_data,
  output logic                            illegal,
  output logic                            halted
);

  // decode to register file
  logic                            rs1_en;
  logic [core_pkg::REG_ADDR_W-1:0] rs1_addr;
  logic [core_pkg::XLEN-1:0]       rs1_data;

  // decode to execute
  logic [core_pkg::XLEN-1:0]       op1;
  logic [core_pkg::XLEN-1:0]       op2;
  logic                            rd_w_en;
  logic [core_pkg::REG_ADDR_W-1:0] rd_addr;
  logic                            jump;
  logic [core_pkg::XLEN-1:0]       imm_j;
  logic                            ebreak;

  // execute back to fetch and register file
  logic                            wb_en;
  logic [core_pkg::REG_ADDR_W-1:0] wb_addr;
  logic [core_pkg::XLEN-1:0]       wb_data;
  logic [core_pkg::XLEN-1:0]       jump_target;

  fetch_unit fetch_unit_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .jump        (jump),
    .ebreak      (ebreak),
    .jump_target (jump_target),
    .pc          (pc),
    .halted      (halted)
  );

  idu idu_inst (
    .inst     (inst),
    .pc       (pc),
    .rs1_data (rs1_data),
    .halted   (halted),
    .rs1_en   (rs1_en),
    .rs1_addr (rs1_addr),
    .op1      (op1),
    .op2      (op2),
    .rd_w_en  (rd_w_en),
    .rd_addr  (rd_addr),
    .jump     (jump),
    .imm_j    (imm_j),
    .ebreak   (ebreak),
    .illegal  (illegal)
  );

  regfile regfile_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_en   (rs1_en),
    .rs1_addr (rs1_addr),
    .wb_en    (wb_en),
    .wb_addr  (wb_addr),
    .wb_data  (wb_data),
    .rs1_data (rs1_data)
  );

  exu exu_inst (
    .op1         (op1),
    .op2         (op2),
    .pc          (pc),
    .imm_j       (imm_j),
    .rd_w_en     (rd_w_en),
    .rd_addr     (rd_addr),
    .jump        (jump),
    .wb_en       (wb_en),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data),
    .jump_target (jump_target),
    .retire      (retire),
    .retire_rd   (retire_rd),
    .retire_data (retire_data)
  );

endmodule

`default_nettype wire

// File: hdl/regfile.sv
`default_nettype none

module regfile (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             rs1_en,
  input  wire  [core_pkg::REG_ADDR_W-1:0] rs1_addr,
  input  wire                             wb_en,
  input  wire  [core_pkg::REG_ADDR_W-1:0] wb_addr,
  input  wire  [core_pkg::XLEN-1:0]       wb_data,
  output logic [core_pkg::XLEN-1:0]       rs1_data
);

  localparam int NUM_REGS = 2 ** core_pkg::REG_ADDR_W;

  logic [core_pkg::XLEN-1:0] regs [NUM_REGS];
  logic wr_ok;

  // x0 is hardwired, drop its writes here
  assign wr_ok = wb_en && (wb_addr != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // combinational read, zero for x0 or an idle port
  always_comb begin
    if (rs1_en && (rs1_addr != '0)) begin
      rs1_data = regs[rs1_addr];
    end else begin
      rs1_data = '0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/exu.sv
`default_nettype none

module exu (
  input  wire  [core_pkg::XLEN-1:0]       op1,
  input  wire  [core_pkg::XLEN-1:0]       op2,
  input  wire  [core_pkg::XLEN-1:0]       pc,
  input  wire  [core_pkg::XLEN-1:0]       imm_j,
  input  wire                             rd_w_en,
  input  wire  [core_pkg::REG_ADDR_W-1:0] rd_addr,
  input  wire                             jump,
  output logic                            wb_en,
  output logic [core_pkg::REG_ADDR_W-1:0] wb_addr,
  output logic [core_pkg::XLEN-1:0]       wb_data,
  output logic [core_pkg::XLEN-1:0]       jump_target,
  output logic                            retire,
  output logic [core_pkg::REG_ADDR_W-1:0] retire_rd,
  output logic [core_pkg::XLEN-1:0]       retire_data
);

  logic [core_pkg::XLEN-1:0] sum;

  // one adder covers addi, lui, auipc and the jal link
  assign sum = op1 + op2;
  assign jump_target = pc + imm_j;

  // write-back and retire share one enable
  assign wb_en = rd_w_en;
  assign wb_addr = rd_addr;
  assign wb_data = sum;

  assign retire = rd_w_en;
  assign retire_rd = rd_addr;
  assign retire_data = sum;

  // jal links and lands on a word boundary
  always_comb begin
    if (jump) begin
      jal_writes_a: assert final (retire)
        else $error("jal did not retire with a link write");
      target_aligned_a: assert final (jump_target[1:0] == 2'b00)
        else $error("jal target misaligned: %h", jump_target);
    end
  end

endmodule

`default_nettype wire

// File: idu/idu.sv
`default_nettype none

module idu (
  input  wire  [core_pkg::INST_W-1:0]     inst,
  input  wire  [core_pkg::XLEN-1:0]       pc,
  input  wire  [core_pkg::XLEN-1:0]       rs1_data,
  input  wire                             halted,
  output logic                            rs1_en,
  output logic [core_pkg::REG_ADDR_W-1:0] rs1_addr,
  output logic [core_pkg::XLEN-1:0]       op1,
  output logic [core_pkg::XLEN-1:0]       op2,
  output logic                            rd_w_en,
  output logic [core_pkg::REG_ADDR_W-1:0] rd_addr,
  output logic                            jump,
  output logic [core_pkg::XLEN-1:0]       imm_j,
  output logic                            ebreak,
  output logic                            illegal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [core_pkg::REG_ADDR_W-1:0] rd;
  logic [core_pkg::REG_ADDR_W-1:0] rs1;

  logic [core_pkg::XLEN-1:0] imm_i;
  logic [core_pkg::XLEN-1:0] imm_u;

  logic inst_addi;
  logic inst_lui;
  logic inst_auipc;
  logic inst_jal;
  logic inst_ebreak;
  logic known;

  logic [core_pkg::INST_TYPE_W-1:0] inst_type;

  // instruction fields
  assign opcode = inst[6:0];
  assign rd = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1 = inst[19:15];

  // immediates, all sign extended from inst[31]
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  // J offset is scattered over the upper 20 bits
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign inst_addi = (opcode == core_pkg::OPC_OP_IMM) && (funct3 == core_pkg::F3_ADDI);
  assign inst_lui = (opcode == core_pkg::OPC_LUI);
  assign inst_auipc = (opcode == core_pkg::OPC_AUIPC);
  assign inst_jal = (opcode == core_pkg::OPC_JAL);
  // opcode alone is not enough here, ecall shares SYSTEM
  assign inst_ebreak = (inst == core_pkg::EBREAK_INST);

  assign known = inst_addi | inst_lui | inst_auipc | inst_jal | inst_ebreak;

  // R, S and B never decode in this subset
  assign inst_type = {inst_jal, inst_lui | inst_auipc, 1'b0, 1'b0, inst_addi, 1'b0};

  // operand and register-port selection by type
  always_comb begin
    op1 = '0;
    op2 = '0;
    rs1_en = 1'b0;
    rs1_addr = '0;
    rd_w_en = 1'b0;
    rd_addr = '0;

    case (inst_type)
      core_pkg::TYPE_I: begin
        op1 = rs1_data;
        op2 = imm_i;
        rs1_en = !halted;
        rs1_addr = rs1;
        rd_w_en = !halted;
        rd_addr = rd;
      end
      core_pkg::TYPE_U: begin
        // lui adds to zero, auipc to the pc
        op1 = inst_auipc ? pc : '0;
        op2 = imm_u;
        rd_w_en = !halted;
        rd_addr = rd;
      end
      core_pkg::TYPE_J: begin
        // link value pc + 4
        op1 = pc;
        op2 = {{(core_pkg::XLEN-3){1'b0}}, 3'd4};
        rd_w_en = !halted;
        rd_addr = rd;
      end
      default: begin
        op1 = '0;
        op2 = '0;
      end
    endcase
  end

  assign jump = inst_jal & ~halted;
  assign ebreak = inst_ebreak & ~halted;
  assign illegal = ~known & ~halted;

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`default_nettype none

module fetch_unit (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       jump,
  input  wire                       ebreak,
  input  wire  [core_pkg::XLEN-1:0] jump_target,
  output logic [core_pkg::XLEN-1:0] pc,
  output logic                      halted
);

  logic [core_pkg::XLEN-1:0] pc_seq;
  logic [core_pkg::XLEN-1:0] pc_next;

  assign pc_seq = pc + {{(core_pkg::XLEN-3){1'b0}}, 3'd4};

  // jal redirects, everything else falls through
  assign pc_next = jump ? jump_target : pc_seq;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= core_pkg::RESET_PC;
      halted <= 1'b0;
    end else begin
      // sticky until reset
      if (ebreak) begin
        halted <= 1'b1;
      end
      // pc stays on the ebreak itself
      if (!halted && !ebreak) begin
        pc <= pc_next;
      end
    end
  end

  // alignment relies on the jump target formed in exu
  pc_aligned_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    pc[1:0] == 2'b00
  ) else $error("pc not word aligned: %h", pc);

  pc_frozen_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    halted |=> $stable(pc)
  ) else $error("pc moved while halted");

endmodule

`default_nettype wire

// File: common/core_pkg.sv
`default_nettype none

package core_pkg;

  // datapath and address width
  localparam int XLEN = 64;
  localparam int INST_W = 32;
  localparam int REG_ADDR_W = 5;

  // first fetch after reset
  localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_JAL = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // funct3, inst[14:12]
  localparam logic [2:0] F3_ADDI = 3'b000;

  // one-hot instruction type
  // bit 0 R, 1 I, 2 S, 3 B, 4 U, 5 J
  localparam int INST_TYPE_W = 6;
  localparam logic [INST_TYPE_W-1:0] TYPE_I = 6'b00_0010;
  localparam logic [INST_TYPE_W-1:0] TYPE_U = 6'b01_0000;
  localparam logic [INST_TYPE_W-1:0] TYPE_J = 6'b10_0000;

  // whole ebreak word, funct12 = 1 under SYSTEM
  localparam logic [INST_W-1:0] EBREAK_INST = 32'h0010_0073;

endpackage

`default_nettype wire
